// ==== include/rename_defines.svh ====
// Rename stage sizing for group width, register counts and index widths
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Instructions renamed per cycle
`define RENAME_WIDTH 4

`define NUM_LOGICAL 32
`define NUM_PHYSICAL 64

`define LOG_REG_BITS 5
`define PHYS_REG_BITS 6

// Physical registers not held by the architectural map
`define FREE_LIST_SIZE (`NUM_PHYSICAL - `NUM_LOGICAL)
`define FREE_LIST_BITS 5

`endif

// ==== hw/renamePkg.sv ====
// Shared types for incoming, renamed, free and committing rename slots
`include "rename_defines.svh"

package renamePkg;

  typedef logic [`LOG_REG_BITS-1:0] logRegT;
  typedef logic [`PHYS_REG_BITS-1:0] physRegT;

  typedef struct packed {
    logic   valid;
    logRegT src0;
    logRegT src1;
    logic   hasDest;
    logRegT dest;
  } renameSlotT;

  typedef struct packed {
    logic    valid;
    physRegT src0Phys;
    physRegT src1Phys;
    logic    hasDest;
    logRegT  dest;
    physRegT newPhys;
    physRegT oldPhys;
  } renamedSlotT;

  typedef struct packed {
    logic    valid;
    physRegT physReg;
  } freeRegT;

  typedef struct packed {
    logic    valid;
    logRegT  logDest;
    physRegT newPhys;
    physRegT oldPhys;
  } commitSlotT;

  typedef struct packed {
    logic    en;
    logRegT  logReg;
    physRegT physReg;
  } mapWriteT;

  typedef renameSlotT [`RENAME_WIDTH-1:0] renameGroupT;
  typedef renamedSlotT [`RENAME_WIDTH-1:0] renamedGroupT;
  typedef freeRegT [`RENAME_WIDTH-1:0] freeRegGroupT;
  typedef commitSlotT [`RENAME_WIDTH-1:0] commitGroupT;
  typedef mapWriteT [`RENAME_WIDTH-1:0] mapWriteGroupT;

endpackage

// ==== hw/freeListRam.sv ====
// Four-read four-write circular storage of free physical register numbers
`timescale 1ns/1ps
`include "rename_defines.svh"

module freeListRam (
  input  logic                                          clk,
  input  logic                                          reset,
  input  logic [`RENAME_WIDTH-1:0][`FREE_LIST_BITS-1:0] readAddr_i,
  input  logic [`RENAME_WIDTH-1:0]                      writeEn_i,
  input  logic [`RENAME_WIDTH-1:0][`FREE_LIST_BITS-1:0] writeAddr_i,
  input  logic [`RENAME_WIDTH-1:0][`PHYS_REG_BITS-1:0]  writeData_i,
  output logic [`RENAME_WIDTH-1:0][`PHYS_REG_BITS-1:0]  readData_o
);

  logic [`PHYS_REG_BITS-1:0] mem [`FREE_LIST_SIZE];

  always_comb begin
    for (int k = 0; k < `RENAME_WIDTH; k++) begin
      readData_o[k] = mem[readAddr_i[k]];
    end
  end

  // At reset every register above the identity-mapped ones is free
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `FREE_LIST_SIZE; i++) begin
        mem[i] <= `PHYS_REG_BITS'(`NUM_LOGICAL + i);
      end
    end else begin
      for (int k = 0; k < `RENAME_WIDTH; k++) begin
        if (writeEn_i[k]) begin
          mem[writeAddr_i[k]] <= writeData_i[k];
        end
      end
    end
  end

endmodule

// ==== hw/specFreeList.sv ====
// Speculative free list popping and pushing up to four physical registers per cycle
`timescale 1ns/1ps
`include "rename_defines.svh"

module specFreeList (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   stall_i,
  input  logic                   recoverFlag_i,
  input  logic [`RENAME_WIDTH-1:0] popReq_i,
  input  renamePkg::commitGroupT  commitGroup_i,
  output renamePkg::freeRegGroupT freeRegs_o,
  output logic                   freeListEmpty_o
);
  import renamePkg::*;

  localparam int CntBits = `FREE_LIST_BITS + 1;

  logic [`FREE_LIST_BITS-1:0] freeListHead;
  logic [`FREE_LIST_BITS-1:0] freeListTail;
  logic [CntBits-1:0]         freeListCnt;
  logic [`FREE_LIST_BITS-1:0] headNext;
  logic [`FREE_LIST_BITS-1:0] tailNext;
  logic [CntBits-1:0]         popCnt;
  logic [CntBits-1:0]         pushCnt;
  logic                       popOk;

  logic [`RENAME_WIDTH-1:0][`FREE_LIST_BITS-1:0] readAddr;
  logic [`RENAME_WIDTH-1:0][`FREE_LIST_BITS-1:0] writeAddr;
  logic [`RENAME_WIDTH-1:0]                      writeEn;
  physRegT [`RENAME_WIDTH-1:0]                   writeData;
  physRegT [`RENAME_WIDTH-1:0]                   readData;

  function automatic logic [`FREE_LIST_BITS-1:0] wrapIdx(input logic [CntBits-1:0] raw);
    if (raw >= `FREE_LIST_SIZE) begin
      return `FREE_LIST_BITS'(raw - `FREE_LIST_SIZE);
    end
    return raw[`FREE_LIST_BITS-1:0];
  endfunction

  freeListRam ram (
    .clk        (clk),
    .reset      (reset),
    .readAddr_i (readAddr),
    .writeEn_i  (writeEn),
    .writeAddr_i(writeAddr),
    .writeData_i(writeData),
    .readData_o (readData)
  );

  // A whole group's worth must be free before any register is handed out
  assign freeListEmpty_o = freeListCnt < `RENAME_WIDTH;
  assign popOk = ~freeListEmpty_o & ~stall_i;

  always_comb begin
    for (int k = 0; k < `RENAME_WIDTH; k++) begin
      freeRegs_o[k].valid = popOk;
      freeRegs_o[k].physReg = readData[k];
    end
  end

  // Valid commits land on consecutive slots from the tail, in slot order
  always_comb begin
    popCnt = '0;
    pushCnt = '0;
    for (int k = 0; k < `RENAME_WIDTH; k++) begin
      readAddr[k] = wrapIdx({1'b0, freeListHead} + CntBits'(k));
      writeAddr[k] = wrapIdx({1'b0, freeListTail} + pushCnt);
      writeEn[k] = commitGroup_i[k].valid;
      writeData[k] = commitGroup_i[k].oldPhys;
      pushCnt = pushCnt + CntBits'(commitGroup_i[k].valid);
      popCnt = popCnt + CntBits'(popOk & popReq_i[k]);
    end
    headNext = wrapIdx({1'b0, freeListHead} + popCnt);
    tailNext = wrapIdx({1'b0, freeListTail} + pushCnt);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      freeListHead <= '0;
      freeListTail <= '0;
      freeListCnt <= CntBits'(`FREE_LIST_SIZE);
    end else begin
      freeListTail <= tailNext;
      if (recoverFlag_i) begin
        // Everything outside the architectural map becomes free again
        freeListHead <= tailNext;
        freeListCnt <= CntBits'(`FREE_LIST_SIZE);
      end else begin
        freeListHead <= headNext;
        freeListCnt <= freeListCnt - popCnt + pushCnt;
      end
    end
  end

endmodule

// ==== hw/renameMapTable.sv ====
// Speculative and architectural rename maps with group lookup and flush restore
`timescale 1ns/1ps
`include "rename_defines.svh"

module renameMapTable (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      recoverFlag_i,
  input  renamePkg::renameGroupT                    lookupGroup_i,
  input  renamePkg::mapWriteGroupT                  mapWrite_i,
  input  renamePkg::commitGroupT                    commitGroup_i,
  output renamePkg::physRegT [2*`RENAME_WIDTH-1:0]  srcPhys_o,
  output renamePkg::physRegT [`RENAME_WIDTH-1:0]    destOldPhys_o
);
  import renamePkg::*;

  physRegT specMap [`NUM_LOGICAL];
  physRegT archMap [`NUM_LOGICAL];

  always_comb begin
    for (int k = 0; k < `RENAME_WIDTH; k++) begin
      srcPhys_o[2*k] = specMap[lookupGroup_i[k].src0];
      srcPhys_o[2*k+1] = specMap[lookupGroup_i[k].src1];
      destOldPhys_o[k] = specMap[lookupGroup_i[k].dest];
    end
  end

  // Slots are written in order so the youngest writer of a register wins
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_LOGICAL; i++) begin
        specMap[i] <= physRegT'(i);
      end
    end else if (recoverFlag_i) begin
      for (int i = 0; i < `NUM_LOGICAL; i++) begin
        specMap[i] <= archMap[i];
      end
      // Commits in the flush cycle are part of the restored state
      for (int k = 0; k < `RENAME_WIDTH; k++) begin
        if (commitGroup_i[k].valid) begin
          specMap[commitGroup_i[k].logDest] <= commitGroup_i[k].newPhys;
        end
      end
    end else begin
      for (int k = 0; k < `RENAME_WIDTH; k++) begin
        if (mapWrite_i[k].en) begin
          specMap[mapWrite_i[k].logReg] <= mapWrite_i[k].physReg;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_LOGICAL; i++) begin
        archMap[i] <= physRegT'(i);
      end
    end else begin
      for (int k = 0; k < `RENAME_WIDTH; k++) begin
        if (commitGroup_i[k].valid) begin
          archMap[commitGroup_i[k].logDest] <= commitGroup_i[k].newPhys;
        end
      end
    end
  end

endmodule

// ==== hw/renameCombine.sv ====
// Combines free registers with map lookups, resolves in-group hazards and registers the group
`timescale 1ns/1ps
`include "rename_defines.svh"

module renameCombine (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     stall_i,
  input  logic                                     recoverFlag_i,
  input  renamePkg::renameGroupT                   renameGroup_i,
  input  renamePkg::freeRegGroupT                  freeRegs_i,
  input  renamePkg::physRegT [2*`RENAME_WIDTH-1:0] srcPhys_i,
  input  renamePkg::physRegT [`RENAME_WIDTH-1:0]   destOldPhys_i,
  output renamePkg::mapWriteGroupT                 mapWrite_o,
  output renamePkg::renamedGroupT                  renamedGroup_o
);
  import renamePkg::*;

  localparam int GrantBits = $clog2(`RENAME_WIDTH);

  renamedGroupT             renamedNext;
  renamedGroupT             renamedQ;
  logic [`RENAME_WIDTH-1:0] needsDest;
  logic                     missing;
  logic                     accept;

  always_comb begin : allocate
    logic [GrantBits-1:0] grant;
    grant = '0;
    missing = 1'b0;
    for (int k = 0; k < `RENAME_WIDTH; k++) begin
      needsDest[k] = renameGroup_i[k].valid & renameGroup_i[k].hasDest;
      renamedNext[k].valid = renameGroup_i[k].valid;
      renamedNext[k].hasDest = renameGroup_i[k].hasDest;
      renamedNext[k].dest = renameGroup_i[k].dest;
      renamedNext[k].newPhys = freeRegs_i[grant].physReg;
      renamedNext[k].src0Phys = srcPhys_i[2*k];
      renamedNext[k].src1Phys = srcPhys_i[2*k+1];
      renamedNext[k].oldPhys = destOldPhys_i[k];
      // Walking older slots upward leaves the newest producer in place
      for (int j = 0; j < k; j++) begin
        if (needsDest[j]) begin
          if (renameGroup_i[j].dest == renameGroup_i[k].src0) begin
            renamedNext[k].src0Phys = renamedNext[j].newPhys;
          end
          if (renameGroup_i[j].dest == renameGroup_i[k].src1) begin
            renamedNext[k].src1Phys = renamedNext[j].newPhys;
          end
          if (renameGroup_i[j].dest == renameGroup_i[k].dest) begin
            renamedNext[k].oldPhys = renamedNext[j].newPhys;
          end
        end
      end
      if (needsDest[k]) begin
        missing = missing | ~freeRegs_i[grant].valid;
        grant = grant + 1'b1;
      end
    end

    accept = ~missing & ~stall_i;
    for (int k = 0; k < `RENAME_WIDTH; k++) begin
      renamedNext[k].valid = renameGroup_i[k].valid & accept;
      mapWrite_o[k].en = needsDest[k] & accept;
      mapWrite_o[k].logReg = renameGroup_i[k].dest;
      mapWrite_o[k].physReg = renamedNext[k].newPhys;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      renamedQ <= renamedNext;
    end
    if (reset || recoverFlag_i) begin
      for (int k = 0; k < `RENAME_WIDTH; k++) begin
        renamedQ[k].valid <= 1'b0;
      end
    end
  end

  assign renamedGroup_o = renamedQ;

endmodule

// ==== hw/renameTop.sv ====
// Rename stage top joining the free list, map table and group combiner
`timescale 1ns/1ps
`include "rename_defines.svh"

module renameTop (
  input  logic                    clk,
  input  logic                    reset,
  input  renamePkg::renameGroupT  renameGroup_i,
  input  logic                    stall_i,
  input  renamePkg::commitGroupT  commitGroup_i,
  input  logic                    recoverFlag_i,
  output renamePkg::renamedGroupT renamedGroup_o,
  output logic                    freeListEmpty_o
);
  import renamePkg::*;

  logic [`RENAME_WIDTH-1:0]    popReq;
  freeRegGroupT                freeRegs;
  mapWriteGroupT               mapWrite;
  physRegT [2*`RENAME_WIDTH-1:0] srcPhys;
  physRegT [`RENAME_WIDTH-1:0]   destOldPhys;

  for (genvar k = 0; k < `RENAME_WIDTH; k++) begin : gPopReq
    assign popReq[k] = renameGroup_i[k].valid & renameGroup_i[k].hasDest;
  end

  specFreeList freeList (
    .clk            (clk),
    .reset          (reset),
    .stall_i        (stall_i),
    .recoverFlag_i  (recoverFlag_i),
    .popReq_i       (popReq),
    .commitGroup_i  (commitGroup_i),
    .freeRegs_o     (freeRegs),
    .freeListEmpty_o(freeListEmpty_o)
  );

  renameMapTable mapTable (
    .clk          (clk),
    .reset        (reset),
    .recoverFlag_i(recoverFlag_i),
    .lookupGroup_i(renameGroup_i),
    .mapWrite_i   (mapWrite),
    .commitGroup_i(commitGroup_i),
    .srcPhys_o    (srcPhys),
    .destOldPhys_o(destOldPhys)
  );

  renameCombine combine (
    .clk           (clk),
    .reset         (reset),
    .stall_i       (stall_i),
    .recoverFlag_i (recoverFlag_i),
    .renameGroup_i (renameGroup_i),
    .freeRegs_i    (freeRegs),
    .srcPhys_i     (srcPhys),
    .destOldPhys_i (destOldPhys),
    .mapWrite_o    (mapWrite),
    .renamedGroup_o(renamedGroup_o)
  );

endmodule

// ==== verification/renameFlow_checker.sv ====
// Assertions on free list occupancy and grant validity, bound into the free list
`timescale 1ns/1ps
`include "rename_defines.svh"

module renameFlow_checker (
  input logic                     clk,
  input logic                     reset,
  input logic [`FREE_LIST_BITS:0] freeListCnt_i,
  input logic                     freeListEmpty_i
);

  countBounded: assert property (@(posedge clk) disable iff (reset)
    freeListCnt_i <= `FREE_LIST_SIZE)
    else $error("Free list count %0d is above its capacity", freeListCnt_i);

  // No register may leave the list while less than a group is left
  noPopWhenEmpty: assert property (@(posedge clk) disable iff (reset)
    freeListEmpty_i |=> freeListCnt_i >= $past(freeListCnt_i))
    else $error("Free registers were taken while the free list was empty");

endmodule

bind specFreeList renameFlow_checker flowChecker (
  .clk            (clk),
  .reset          (reset),
  .freeListCnt_i  (freeListCnt),
  .freeListEmpty_i(freeListEmpty_o)
);

// ==== verification/renameTb.sv ====
// Directed testbench for the rename stage against a free list and rename map reference model
`timescale 1ns/1ps
`include "rename_defines.svh"

module renameTb;
  import renamePkg::*;

  logic         clk;
  logic         reset;
  renameGroupT  renameGroup;
  logic         stall;
  commitGroupT  commitGroup;
  logic         recoverFlag;
  renamedGroupT renamedGroup;
  logic         freeListEmpty;

  int unsigned  errors;
  int unsigned  checks;
  logic [31:0]  lcgState;

  // The pending queue holds renamed but uncommitted destinations in rename order
  int           freeQ[$];
  int           specMap[`NUM_LOGICAL];
  int           archMap[`NUM_LOGICAL];
  commitSlotT   pending[$];

  renameTop dut (
    .clk            (clk),
    .reset          (reset),
    .renameGroup_i  (renameGroup),
    .stall_i        (stall),
    .commitGroup_i  (commitGroup),
    .recoverFlag_i  (recoverFlag),
    .renamedGroup_o (renamedGroup),
    .freeListEmpty_o(freeListEmpty)
  );

  always #10 clk = ~clk;

  function automatic logRegT randReg(input int lo);
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return logRegT'(lo + int'(lcgState[31:16]) % (`NUM_LOGICAL - lo));
  endfunction

  function automatic renameSlotT makeSlot(input int s0, input int s1, input int d, input bit hasD);
    renameSlotT s;
    s.valid = 1'b1;
    s.src0 = logRegT'(s0);
    s.src1 = logRegT'(s1);
    s.hasDest = hasD;
    s.dest = logRegT'(d);
    return s;
  endfunction

  function automatic renameGroupT randomGroup();
    renameGroupT g;
    for (int k = 0; k < `RENAME_WIDTH; k++) begin
      g[k] = makeSlot(randReg(0), randReg(0), randReg(0), 1'b1);
    end
    return g;
  endfunction

  function automatic bit anyValid(input renamedGroupT r);
    bit v;
    v = 1'b0;
    for (int k = 0; k < `RENAME_WIDTH; k++) begin
      v = v | (r[k].valid === 1'b1);
    end
    return v;
  endfunction

  task automatic expectEq(input string what, input int got, input int want);
    checks++;
    if (got != want) begin
      errors++;
      $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, want);
    end
  endtask

  task automatic checkEmptyFlag();
    @(negedge clk);
    expectEq("freeListEmpty_o", int'(freeListEmpty), int'(freeQ.size() < `RENAME_WIDTH));
  endtask

  // Slots are renamed one after another, so later slots see earlier destinations
  task automatic renameGroupCheck(input renameGroupT g, input bit stallAfter);
    renamedGroupT expGroup;
    commitSlotT   rec;
    int           waitCycles;
    expGroup = '0;
    for (int k = 0; k < `RENAME_WIDTH; k++) begin
      expGroup[k].valid = g[k].valid;
      if (g[k].valid) begin
        expGroup[k].src0Phys = physRegT'(specMap[g[k].src0]);
        expGroup[k].src1Phys = physRegT'(specMap[g[k].src1]);
        if (g[k].hasDest) begin
          expGroup[k].oldPhys = physRegT'(specMap[g[k].dest]);
          expGroup[k].newPhys = physRegT'(freeQ.pop_front());
          specMap[g[k].dest] = int'(expGroup[k].newPhys);
          rec = '{1'b1, g[k].dest, expGroup[k].newPhys, expGroup[k].oldPhys};
          pending.push_back(rec);
        end
      end
    end
    @(posedge clk);
    renameGroup <= g;
    @(posedge clk);
    renameGroup <= '0;
    stall <= stallAfter;
    waitCycles = 0;
    @(negedge clk);
    while (!anyValid(renamedGroup) && waitCycles < 8) begin
      @(negedge clk);
      waitCycles++;
    end
    if (!anyValid(renamedGroup)) begin
      errors++;
      $display("Timed out at %0t ns waiting for a renamed group", $time);
    end else begin
      expectEq("renamed group latency in cycles", waitCycles, 0);
      for (int k = 0; k < `RENAME_WIDTH; k++) begin
        expectEq($sformatf("slot %0d valid", k), int'(renamedGroup[k].valid),
                 int'(expGroup[k].valid));
        if (expGroup[k].valid) begin
          expectEq($sformatf("slot %0d src0", k), int'(renamedGroup[k].src0Phys),
                   int'(expGroup[k].src0Phys));
          expectEq($sformatf("slot %0d src1", k), int'(renamedGroup[k].src1Phys),
                   int'(expGroup[k].src1Phys));
          expectEq($sformatf("slot %0d has dest", k), int'(renamedGroup[k].hasDest),
                   int'(g[k].hasDest));
          if (g[k].hasDest) begin
            expectEq($sformatf("slot %0d logical dest", k), int'(renamedGroup[k].dest),
                     int'(g[k].dest));
            expectEq($sformatf("slot %0d new dest", k), int'(renamedGroup[k].newPhys),
                     int'(expGroup[k].newPhys));
            expectEq($sformatf("slot %0d old dest", k), int'(renamedGroup[k].oldPhys),
                     int'(expGroup[k].oldPhys));
          end
        end
      end
    end
  endtask

  task automatic commitInstrs(input int n);
    commitGroupT cg;
    int          k;
    while (n > 0) begin
      cg = '0;
      for (k = 0; k < `RENAME_WIDTH && n > 0; k++) begin
        cg[k] = pending.pop_front();
        freeQ.push_back(int'(cg[k].oldPhys));
        archMap[cg[k].logDest] = int'(cg[k].newPhys);
        n--;
      end
      @(posedge clk);
      commitGroup <= cg;
    end
    @(posedge clk);
    commitGroup <= '0;
  endtask

  task automatic waitNotEmpty();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (freeListEmpty !== 1'b0 && cycles < 8) begin
      @(negedge clk);
      cycles++;
    end
    if (freeListEmpty !== 1'b0) begin
      errors++;
      $display("Free list stayed empty after commits at %0t ns", $time);
    end
  endtask

  task automatic flushPipe();
    commitSlotT rec;
    @(posedge clk);
    recoverFlag <= 1'b1;
    @(posedge clk);
    recoverFlag <= 1'b0;
    // Uncommitted destinations go back in front of the remaining free registers
    while (pending.size() > 0) begin
      rec = pending.pop_back();
      freeQ.push_front(int'(rec.newPhys));
    end
    specMap = archMap;
  endtask

  task automatic firstAllocation();
    renameGroupT g;
    for (int k = 0; k < `RENAME_WIDTH; k++) begin
      g[k] = makeSlot(randReg(8), randReg(8), k + 1, 1'b1);
    end
    renameGroupCheck(g, 1'b0);
    for (int k = 0; k < `RENAME_WIDTH; k++) begin
      expectEq("first destination", int'(renamedGroup[k].newPhys), `NUM_LOGICAL + k);
    end
  endtask

  task automatic groupDependencies();
    renameGroupT g;
    g[0] = makeSlot(randReg(8), randReg(8), 5, 1'b1);
    g[1] = makeSlot(5, randReg(8), 0, 1'b0);
    g[2] = makeSlot(randReg(8), 5, 5, 1'b1);
    g[3] = makeSlot(5, 6, 6, 1'b1);
    renameGroupCheck(g, 1'b0);
  endtask

  task automatic exhaustionAndStall();
    renamedGroupT held;
    while (freeQ.size() >= `RENAME_WIDTH) begin
      renameGroupCheck(randomGroup(), freeQ.size() < 2 * `RENAME_WIDTH);
    end
    held = renamedGroup;
    checkEmptyFlag();
    @(posedge clk);
    renameGroup <= randomGroup();
    repeat (4) begin
      @(negedge clk);
      checks++;
      if (renamedGroup !== held) begin
        errors++;
        $display("[FAIL] %0t ns: renamed group changed while stalled", $time);
      end
    end
    @(posedge clk);
    stall <= 1'b0;
    repeat (3) begin
      @(posedge clk);
      @(negedge clk);
      expectEq("held group valid", int'(anyValid(renamedGroup)), 0);
    end
    @(posedge clk);
    renameGroup <= '0;
  endtask

  task automatic commitRecycling();
    commitInstrs(8);
    waitNotEmpty();
    repeat (2) begin
      renameGroupCheck(randomGroup(), 1'b0);
    end
    checkEmptyFlag();
  endtask

  task automatic flushRecovery();
    commitInstrs(4);
    renameGroupCheck(randomGroup(), 1'b0);
    flushPipe();
    checkEmptyFlag();
    renameGroupCheck(randomGroup(), 1'b0);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    stall = 1'b0;
    recoverFlag = 1'b0;
    renameGroup = '0;
    commitGroup = '0;
    errors = 0;
    checks = 0;
    lcgState = 32'h6cb040f9;
    for (int i = 0; i < `NUM_LOGICAL; i++) begin
      specMap[i] = i;
      archMap[i] = i;
    end
    for (int i = 0; i < `FREE_LIST_SIZE; i++) begin
      freeQ.push_back(`NUM_LOGICAL + i);
    end
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    expectEq("valid after reset", int'(anyValid(renamedGroup)), 0);
    expectEq("freeListEmpty_o after reset", int'(freeListEmpty), 0);
    firstAllocation();
    groupDependencies();
    exhaustionAndStall();
    commitRecycling();
    flushRecovery();
    repeat (2) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+include
hw/renamePkg.sv
hw/freeListRam.sv
hw/specFreeList.sv
hw/renameMapTable.sv
hw/renameCombine.sv
hw/renameTop.sv
verification/renameFlow_checker.sv
verification/renameTb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module renameTb -f sim.f -o renameSim \
  || { echo "Verilator build failed"; exit 1; }
simOut="$(./obj_dir/renameSim)"
echo "$simOut"
grep -qx "PASS: all tests" <<< "$simOut" && exit 0 || { echo "Simulation failed"; exit 1; }
